// File: Makefile
TOP = mesosync_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q '^=== PASS ===$$'

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+include
logic/mesosync_pkg.sv
logic/relay_fifo.sv
logic/credit_input_fifo.sv
logic/credit_to_token.sv
logic/ready_to_credit_counter.sv
logic/mesosync_core.sv
sim/clock_gen.sv
sim/mesosync_assertions.sv
sim/mesosync_tb.sv

// File: include/mesosync_macros.svh
// default sizes for the mesosync link core
// included by the package, the RTL modules and the testbench
// override on the compile line to build other link configurations
`ifndef MESOSYNC_MACROS_SVH
`define MESOSYNC_MACROS_SVH

// bits per data word on both the core and channel sides
`define MESO_WIDTH 16

// depth of the channel input FIFO, also the far-side buffer depth
`define MESO_FIFO_ELS 4

// credits held toward the channel after reset
`define MESO_CREDIT_INIT 4

// ceiling of the credit counters, sets their width
`define MESO_CREDIT_MAX 7

// credits carried by one token pulse
`define MESO_DECIMATION 2

`endif

// File: logic/credit_input_fifo.sv
// small circular FIFO for words arriving from the channel
// the sender is bound by credits so there is no input ready
// every dequeue pulses credit_o to free one far-side credit
// consumer dequeues with yumi_i, high only when v_o is high

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module credit_input_fifo #(
    parameter int els_p = `MESO_FIFO_ELS
) (
    input  logic                      clk_i,
    input  logic                      rst_i,

    // channel side
    input  logic                      v_i,
    input  mesosync_pkg::meso_word_t  data_i,
    output logic                      credit_o,

    // consumer side
    output logic                      v_o,
    output mesosync_pkg::meso_word_t  data_o,
    input  logic                      yumi_i
);

    localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
    localparam int cnt_w_lp = $clog2(els_p + 1);
    localparam logic [ptr_w_lp-1:0] last_ptr_lp = ptr_w_lp'(els_p - 1);

    mesosync_pkg::meso_word_t mem_r [els_p];
    logic [ptr_w_lp-1:0]      wr_ptr_r;
    logic [ptr_w_lp-1:0]      rd_ptr_r;
    logic [cnt_w_lp-1:0]      count_r;
    logic                     deq;

    // data shows on the output the cycle after it is written
    assign v_o    = (count_r != '0);
    assign data_o = mem_r[rd_ptr_r];

    // dequeue only counts when there is something to take
    assign deq = yumi_i & v_o;

    // one credit per freed slot, same cycle as the dequeue
    assign credit_o = deq;

    // pointers wrap at els_p, so any depth works
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= '0;
            rd_ptr_r <= '0;
            count_r  <= '0;
        end else begin
            if (v_i) begin
                if (wr_ptr_r == last_ptr_lp)
                    wr_ptr_r <= '0;
                else
                    wr_ptr_r <= wr_ptr_r + 1'b1;
            end
            if (deq) begin
                if (rd_ptr_r == last_ptr_lp)
                    rd_ptr_r <= '0;
                else
                    rd_ptr_r <= rd_ptr_r + 1'b1;
            end
            // occupancy moves only when exactly one side is active
            if (v_i && !deq)
                count_r <= count_r + 1'b1;
            else if (!v_i && deq)
                count_r <= count_r - 1'b1;
        end
    end

    // word storage
    always_ff @(posedge clk_i) begin
        if (v_i)
            mem_r[wr_ptr_r] <= data_i;
    end

endmodule

// File: logic/credit_to_token.sv
// batches single credits into token pulses toward the far side
// one token stands for decimation_p credits
// a token waits in a flop until line_ready_i lets it out

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module credit_to_token #(
    parameter int decimation_p = `MESO_DECIMATION,
    parameter int max_val_p    = `MESO_CREDIT_MAX
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic credit_i,
    input  logic line_ready_i,
    output logic token_o
);

    localparam int cnt_w_lp = $clog2(max_val_p + 1);
    localparam logic [cnt_w_lp:0] dec_lp = (cnt_w_lp + 1)'(decimation_p);
    localparam logic [cnt_w_lp:0] max_lp = (cnt_w_lp + 1)'(max_val_p);

    logic [cnt_w_lp-1:0] count_r;
    logic [cnt_w_lp:0]   base;
    logic [cnt_w_lp:0]   sum;
    logic                pending_r;
    logic                fire;
    logic                load;

    // pending token goes out on the first cycle the line is ready
    assign fire    = pending_r & line_ready_i;
    assign token_o = fire;

    // refill the pending flop once it is empty or leaving this cycle
    assign load = (~pending_r | fire) & ({1'b0, count_r} >= dec_lp);

    // credits taken by a new token, then the incoming credit
    assign base = load ? ({1'b0, count_r} - dec_lp) : {1'b0, count_r};
    assign sum  = base + {{cnt_w_lp{1'b0}}, credit_i};

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count_r   <= '0;
            pending_r <= 1'b0;
        end else begin
            // saturate rather than wrap
            if (sum > max_lp)
                count_r <= max_lp[cnt_w_lp-1:0];
            else
                count_r <= sum[cnt_w_lp-1:0];
            pending_r <= load | (pending_r & ~fire);
        end
    end

endmodule

// File: logic/mesosync_core.sv
// top of the mesosync link core
// joins a valid/ready core port to a valid/token channel port
// normal mode moves words both ways, loopback mode returns
// channel words straight back to the channel for calibration
// line_ready_i gates every send and token on the channel

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module mesosync_core (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      loopback_en_i,
    input  logic                      line_ready_i,

    // channel, incoming words and returned tokens
    input  mesosync_pkg::meso_word_t  meso_data_i,
    input  logic                      meso_v_i,
    output logic                      meso_token_o,

    // channel, outgoing words and received tokens
    output logic                      meso_v_o,
    output mesosync_pkg::meso_word_t  meso_data_o,
    input  logic                      meso_token_i,

    // core, words in
    input  mesosync_pkg::meso_word_t  data_i,
    input  logic                      v_i,
    output logic                      ready_and_o,

    // core, words out
    output logic                      v_o,
    output mesosync_pkg::meso_word_t  data_o,
    input  logic                      ready_and_i
);

    // input relay toward the send path
    logic                     in_relay_v;
    mesosync_pkg::meso_word_t in_relay_data;
    logic                     in_relay_ready;

    // channel FIFO toward the output relay
    logic                     out_relay_v;
    logic                     out_relay_ready;

    // channel FIFO output and its dequeue
    logic                     fifo_v;
    mesosync_pkg::meso_word_t fifo_data;
    logic                     fifo_ready;
    logic                     fifo_yumi;
    logic                     fifo_credit;

    // send path toward the credit counter
    logic                     send_v;
    logic                     send_ready;
    logic                     counter_v;
    logic                     counter_ready;

    relay_fifo #(
        .payload_t (mesosync_pkg::meso_word_t)
    ) input_relay (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (v_i),
        .data_i  (data_i),
        .ready_o (ready_and_o),
        .v_o     (in_relay_v),
        .data_o  (in_relay_data),
        .ready_i (in_relay_ready)
    );

    relay_fifo #(
        .payload_t (mesosync_pkg::meso_word_t)
    ) output_relay (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .v_i     (out_relay_v),
        .data_i  (fifo_data),
        .ready_o (out_relay_ready),
        .v_o     (v_o),
        .data_o  (data_o),
        .ready_i (ready_and_i)
    );

    // the send source is the channel FIFO in loopback, the core otherwise
    assign send_v      = loopback_en_i ? fifo_v : in_relay_v;
    assign meso_data_o = loopback_en_i ? fifo_data : in_relay_data;

    // nothing reaches the counter while the line is down
    assign counter_v  = line_ready_i & send_v;
    assign send_ready = line_ready_i & counter_ready;

    // loopback starves both core-side relays
    assign in_relay_ready = ~loopback_en_i & send_ready;
    assign out_relay_v    = ~loopback_en_i & fifo_v;

    // the FIFO consumer is the send path or the output relay
    assign fifo_ready = loopback_en_i ? send_ready : out_relay_ready;
    assign fifo_yumi  = fifo_ready & fifo_v;

    credit_input_fifo #(
        .els_p (`MESO_FIFO_ELS)
    ) input_fifo (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .v_i      (meso_v_i),
        .data_i   (meso_data_i),
        .credit_o (fifo_credit),
        .v_o      (fifo_v),
        .data_o   (fifo_data),
        .yumi_i   (fifo_yumi)
    );

    // freed FIFO slots go back to the far side as tokens
    credit_to_token #(
        .decimation_p (`MESO_DECIMATION),
        .max_val_p    (`MESO_CREDIT_MAX)
    ) token_converter (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .credit_i     (fifo_credit),
        .line_ready_i (line_ready_i),
        .token_o      (meso_token_o)
    );

    // far-side buffer space, refilled by incoming tokens
    ready_to_credit_counter #(
        .credit_initial_p (`MESO_CREDIT_INIT),
        .credit_max_val_p (`MESO_CREDIT_MAX),
        .decimation_p     (`MESO_DECIMATION)
    ) output_credit_counter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .v_i      (counter_v),
        .ready_o  (counter_ready),
        .v_o      (meso_v_o),
        .credit_i (meso_token_i)
    );

endmodule

// File: logic/mesosync_pkg.sv
// shared types of the mesosync link core
// referenced by scope from the RTL and the testbench
// word width comes from the macros header

`include "mesosync_macros.svh"

package mesosync_pkg;

    // one data word as it crosses the core or the channel
    typedef logic [`MESO_WIDTH-1:0] meso_word_t;

endpackage

// File: logic/ready_to_credit_counter.sv
// credit counter on the send path toward the channel
// grants a send while the far buffer has room
// each token pulse returns decimation_p credits

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module ready_to_credit_counter #(
    parameter int credit_initial_p = `MESO_CREDIT_INIT,
    parameter int credit_max_val_p = `MESO_CREDIT_MAX,
    parameter int decimation_p     = `MESO_DECIMATION
) (
    input  logic clk_i,
    input  logic rst_i,

    // send request and grant
    input  logic v_i,
    output logic ready_o,

    // accepted send toward the channel
    output logic v_o,

    // token from the far side
    input  logic credit_i
);

    localparam int cnt_w_lp = $clog2(credit_max_val_p + 1);
    localparam logic [cnt_w_lp-1:0] init_lp = cnt_w_lp'(credit_initial_p);
    localparam logic [cnt_w_lp:0]   dec_lp  = (cnt_w_lp + 1)'(decimation_p);
    localparam logic [cnt_w_lp:0]   max_lp  = (cnt_w_lp + 1)'(credit_max_val_p);

    logic [cnt_w_lp-1:0] credit_r;
    logic [cnt_w_lp:0]   refill;
    logic [cnt_w_lp:0]   credit_next;
    logic                send;

    // any credit left allows a send
    assign ready_o = (credit_r != '0);

    // strobe goes out in the same cycle the send is granted
    assign send = v_i & ready_o;
    assign v_o  = send;

    // send and token may land together
    assign refill      = credit_i ? dec_lp : '0;
    assign credit_next = {1'b0, credit_r} - {{cnt_w_lp{1'b0}}, send} + refill;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_r <= init_lp;
        end else begin
            // clip at the ceiling, a well behaved far side never hits it
            if (credit_next > max_lp)
                credit_r <= max_lp[cnt_w_lp-1:0];
            else
                credit_r <= credit_next[cnt_w_lp-1:0];
        end
    end

endmodule

// File: logic/relay_fifo.sv
// two-entry valid/ready relay stage with a registered ready
// placed between distant blocks to cut long ready paths
// payload type is a parameter so any word or struct can pass

`timescale 1ns/1ns

module relay_fifo #(
    parameter type payload_t = mesosync_pkg::meso_word_t
) (
    input  logic     clk_i,
    input  logic     rst_i,

    // upstream side
    input  logic     v_i,
    input  payload_t data_i,
    output logic     ready_o,

    // downstream side
    output logic     v_o,
    output payload_t data_o,
    input  logic     ready_i
);

    payload_t   mem_r [2];
    logic       wr_ptr_r;
    logic       rd_ptr_r;
    logic [1:0] count_r;
    logic [1:0] count_next;
    logic       ready_r;
    logic       enq;
    logic       deq;

    // ready is a flop so the upstream sees no path from ready_i
    assign enq = v_i & ready_r;
    assign deq = ready_i & v_o;

    // head entry drives the output
    assign v_o     = (count_r != 2'd0);
    assign data_o  = mem_r[rd_ptr_r];
    assign ready_o = ready_r;

    always_comb begin
        count_next = count_r;
        case ({enq, deq})
            2'b10:   count_next = count_r + 2'd1;
            2'b01:   count_next = count_r - 2'd1;
            default: count_next = count_r;
        endcase
    end

    // control state
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_ptr_r <= 1'b0;
            rd_ptr_r <= 1'b0;
            count_r  <= 2'd0;
            ready_r  <= 1'b1;
        end else begin
            if (enq)
                wr_ptr_r <= ~wr_ptr_r;
            if (deq)
                rd_ptr_r <= ~rd_ptr_r;
            count_r <= count_next;
            // second entry is the skid slot, drop ready once both are used
            ready_r <= (count_next != 2'd2);
        end
    end

    // payload storage
    always_ff @(posedge clk_i) begin
        if (enq)
            mem_r[wr_ptr_r] <= data_i;
    end

endmodule

// File: sim/clock_gen.sv
// clock and reset source for the mesosync testbench
// 10 ns clock, reset high across the first two rising edges

`timescale 1ns/1ns

module clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // free running clock, 5 ns per half period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // reset released on the edge after the second rising edge
    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

// File: sim/mesosync_assertions.sv
// concurrent protocol checks for the mesosync link core
// bound into mesosync_core, each failing assertion bumps its own count
// the testbench reads fail_total through the bound instance

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module mesosync_assertions (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     loopback_en_i,
    input logic                     line_ready_i,
    input logic                     meso_v_o,
    input logic                     meso_token_o,
    input logic                     meso_token_i,
    input logic                     v_o,
    input mesosync_pkg::meso_word_t data_o,
    input logic                     ready_and_i,
    input logic                     ready_and_o
);

    int sent_cnt;
    int token_cnt;
    int reset_fails = 0;
    int credit_fails = 0;
    int hold_fails = 0;
    int line_fails = 0;
    int loop_fails = 0;
    int fail_total;

    assign fail_total = reset_fails + credit_fails + hold_fails + line_fails + loop_fails;

    // strobes sent and tokens returned since reset
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sent_cnt  <= 0;
            token_cnt <= 0;
        end else begin
            if (meso_v_o)
                sent_cnt <= sent_cnt + 1;
            if (meso_token_i)
                token_cnt <= token_cnt + 1;
        end
    end

    // first cycle out of reset, channel quiet and core port open
    reset_idle: assert property (@(posedge clk_i)
        $fell(rst_i) |-> !meso_v_o && !meso_token_o && !v_o && ready_and_o)
        else begin
            $error("outputs not idle on the first cycle after reset");
            reset_fails++;
        end

    // a send this cycle must fit in the initial credit plus returned tokens
    credit_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        meso_v_o |-> sent_cnt < `MESO_CREDIT_INIT + `MESO_DECIMATION * token_cnt)
        else begin
            $error("channel send without a credit");
            credit_fails++;
        end

    // stalled core output keeps valid and data
    hold_under_bp: assert property (@(posedge clk_i) disable iff (rst_i)
        v_o && !ready_and_i |=> v_o && $stable(data_o))
        else begin
            $error("core output changed while stalled");
            hold_fails++;
        end

    line_down_quiet: assert property (@(posedge clk_i) disable iff (rst_i)
        !line_ready_i |-> !meso_v_o && !meso_token_o)
        else begin
            $error("channel activity while the line is not ready");
            line_fails++;
        end

    // loopback keeps the core output idle
    loopback_core_idle: assert property (@(posedge clk_i) disable iff (rst_i)
        loopback_en_i |-> !v_o)
        else begin
            $error("core output valid in loopback mode");
            loop_fails++;
        end

endmodule

bind mesosync_core mesosync_assertions u_checks (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .loopback_en_i (loopback_en_i),
    .line_ready_i  (line_ready_i),
    .meso_v_o      (meso_v_o),
    .meso_token_o  (meso_token_o),
    .meso_token_i  (meso_token_i),
    .v_o           (v_o),
    .data_o        (data_o),
    .ready_and_i   (ready_and_i),
    .ready_and_o   (ready_and_o)
);

// File: sim/mesosync_tb.sv
// testbench for the mesosync link core
// drives the core port, models the far side of the channel and
// checks word order with queues, protocol through the bound assertions

`timescale 1ns/1ns

`include "mesosync_macros.svh"

module mesosync_tb;

    localparam int dec_lp = `MESO_DECIMATION;
    localparam int total_words_lp = 40 + 40 + 30 + 20 + 20;
    localparam int timeout_ns_lp = total_words_lp * 20 * 10 + 2000;

    logic                     clk_i;
    logic                     rst_i;
    logic                     loopback_en_i = 1'b0;
    logic                     line_ready_i = 1'b1;
    mesosync_pkg::meso_word_t meso_data_i = '0;
    logic                     meso_v_i = 1'b0;
    logic                     meso_token_o;
    logic                     meso_v_o;
    mesosync_pkg::meso_word_t meso_data_o;
    logic                     meso_token_i = 1'b0;
    mesosync_pkg::meso_word_t data_i = '0;
    logic                     v_i = 1'b0;
    logic                     ready_and_o;
    logic                     v_o;
    mesosync_pkg::meso_word_t data_o;
    logic                     ready_and_i = 1'b1;

    // words to send and words expected, per direction
    mesosync_pkg::meso_word_t core_in_q[$];
    mesosync_pkg::meso_word_t chan_send_q[$];
    mesosync_pkg::meso_word_t exp_core_q[$];
    mesosync_pkg::meso_word_t exp_chan_q[$];
    mesosync_pkg::meso_word_t core_exp;
    mesosync_pkg::meso_word_t chan_exp;

    // random bits for the per-cycle gaps, filled once at the start
    int         seed = 6517;
    int         pool [512];
    logic [8:0] src_idx = '0;
    logic [8:0] sink_idx = '0;
    logic [8:0] far_idx = '0;

    logic bp_en = 1'b0;
    int   far_credit;
    int   far_rx = 0;
    int   tok_owed = 0;
    int   token_cnt = 0;
    int   core_errs = 0;
    int   chan_errs = 0;
    int   tb_errs = 0;
    int   base;
    int   tok0;

    clock_gen clocks (
        .clk_o (clk_i),
        .rst_o (rst_i)
    );

    mesosync_core i_dut (.*);

    // core source, valid held until the input relay takes the word
    always @(posedge clk_i) begin
        if (rst_i) begin
            v_i <= 1'b0;
        end else if (!v_i || ready_and_o) begin
            if (v_i)
                void'(core_in_q.pop_front());
            if (core_in_q.size() > 0 && pool[src_idx][1:0] != 2'b00) begin
                v_i    <= 1'b1;
                data_i <= core_in_q[0];
            end else begin
                v_i <= 1'b0;
            end
            src_idx <= src_idx + 1'b1;
        end
    end

    // core sink, random stalls only during the back-pressure test
    always @(posedge clk_i) begin
        if (!rst_i && v_o && ready_and_i) begin
            if (exp_core_q.size() == 0) begin
                $display("Error: %0t ns: unexpected word %h on data_o", $time, data_o);
                core_errs++;
            end else begin
                core_exp = exp_core_q.pop_front();
                if (data_o !== core_exp) begin
                    $display("Error: %0t ns: data_o %h, expected %h", $time, data_o, core_exp);
                    core_errs++;
                end
            end
        end
        ready_and_i <= !bp_en || pool[sink_idx][2];
        sink_idx <= sink_idx + 1'b1;
    end

    // far side of the channel, bound by its own credit count
    always @(posedge clk_i) begin
        if (rst_i) begin
            far_credit = `MESO_FIFO_ELS;
            tok_owed   = 0;
            meso_v_i     <= 1'b0;
            meso_token_i <= 1'b0;
        end else begin
            meso_token_i <= 1'b0;
            if (meso_v_o) begin
                if (exp_chan_q.size() == 0) begin
                    $display("Error: %0t ns: unexpected word %h on meso_data_o",
                             $time, meso_data_o);
                    chan_errs++;
                end else begin
                    chan_exp = exp_chan_q.pop_front();
                    if (meso_data_o !== chan_exp) begin
                        $display("Error: %0t ns: meso_data_o %h, expected %h",
                                 $time, meso_data_o, chan_exp);
                        chan_errs++;
                    end
                end
                // one token owed per decimation words
                far_rx++;
                if (far_rx % dec_lp == 0)
                    tok_owed++;
            end
            // owed tokens trickle back, so the send credits run dry at times
            if (tok_owed > 0 && line_ready_i && pool[far_idx][6:5] == 2'b11) begin
                meso_token_i <= 1'b1;
                tok_owed--;
            end
            if (meso_token_o) begin
                far_credit += dec_lp;
                token_cnt++;
            end
            if (chan_send_q.size() > 0 && far_credit > 0 && line_ready_i
                && pool[far_idx][4:3] != 2'b00) begin
                meso_v_i    <= 1'b1;
                meso_data_i <= chan_send_q.pop_front();
                far_credit--;
            end else begin
                meso_v_i <= 1'b0;
            end
            far_idx <= far_idx + 1'b1;
        end
    end

    function automatic int total_errors();
        return core_errs + chan_errs + tb_errs + i_dut.u_checks.fail_total;
    endfunction

    // core words bound for the channel
    task automatic queue_core_words(input int n);
        mesosync_pkg::meso_word_t w;
        for (int i = 0; i < n; i++) begin
            w = mesosync_pkg::meso_word_t'($random(seed));
            core_in_q.push_back(w);
            exp_chan_q.push_back(w);
        end
    endtask

    // channel words, back to the channel in loopback, else to the core
    task automatic queue_channel_words(input int n, input logic loop);
        mesosync_pkg::meso_word_t w;
        for (int i = 0; i < n; i++) begin
            w = mesosync_pkg::meso_word_t'($random(seed));
            chan_send_q.push_back(w);
            if (loop)
                exp_chan_q.push_back(w);
            else
                exp_core_q.push_back(w);
        end
    endtask

    // every expected word seen, then a few cycles for trailing tokens
    task automatic wait_drained();
        while (exp_core_q.size() != 0 || exp_chan_q.size() != 0)
            @(posedge clk_i);
        repeat (4) @(posedge clk_i);
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        int errs_now;
        errs_now = total_errors();
        if (errs_now == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: failed, %0d errors", num, name, errs_now - errs_before);
    endtask

    initial begin
        for (int i = 0; i < 512; i++)
            pool[i] = $random(seed);
        while (rst_i)
            @(posedge clk_i);
        base = total_errors();
        repeat (2) @(posedge clk_i);
        report_test(1, "after reset", base);

        base = total_errors();
        queue_core_words(40);
        wait_drained();
        report_test(2, "core to channel", base);

        // all dequeues of this test return as whole tokens
        base = total_errors();
        tok0 = token_cnt;
        queue_channel_words(40, 1'b0);
        wait_drained();
        if (token_cnt - tok0 != 40 / dec_lp) begin
            $display("Error: %0t ns: %0d tokens, expected %0d",
                     $time, token_cnt - tok0, 40 / dec_lp);
            tb_errs++;
        end
        report_test(3, "channel to core", base);

        base = total_errors();
        bp_en <= 1'b1;
        queue_channel_words(30, 1'b0);
        wait_drained();
        bp_en <= 1'b0;
        report_test(4, "back-pressure", base);

        // line drops with channel words in flight, so a token waits on it
        // core words are queued while the line is down, released later
        base = total_errors();
        queue_channel_words(10, 1'b0);
        while (chan_send_q.size() > 10 - `MESO_FIFO_ELS)
            @(posedge clk_i);
        line_ready_i <= 1'b0;
        queue_core_words(10);
        repeat (20 + ($random(seed) & 15)) @(posedge clk_i);
        line_ready_i <= 1'b1;
        wait_drained();
        report_test(5, "line not ready", base);

        base = total_errors();
        loopback_en_i <= 1'b1;
        @(posedge clk_i);
        queue_channel_words(20, 1'b1);
        wait_drained();
        loopback_en_i <= 1'b0;
        @(posedge clk_i);
        report_test(6, "loopback", base);

        $display("tests run: 6, failed checks: %0d", total_errors());
        if (total_errors() == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog sized from the word count of all tests
    initial begin
        #(timeout_ns_lp);
        $display("run timed out after %0d ns with words still in flight", timeout_ns_lp);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
